/* Makefile */
SRCS := $(wildcard src/*.sv include/*.svh test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu16: list.f $(SRCS)
	verilator --binary --timing --top-module tb_cpu16 --Mdir obj_dir -f list.f

run: obj_dir/Vtb_cpu16
	obj_dir/Vtb_cpu16 > sim.log
	cat sim.log
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/cpu16_params.svh */
// Shared widths, register count, ALU operation codes and reset PC of the cpu16 core
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

`define CPU16_WORD_W   16       // Data and address width
`define CPU16_NREG     16       // Register file depth
`define CPU16_RESET_PC 16'h0000 // First fetch address

// ALUF codes, 8 to 15 decode as MOV
`define ALU_MOV 3'd0 // Ra = arg
`define ALU_ADD 3'd1 // Ra = Ra + arg, C is carry out
`define ALU_SUB 3'd2 // Ra = Ra - arg, C is borrow
`define ALU_AND 3'd3
`define ALU_OR  3'd4
`define ALU_XOR 3'd5
`define ALU_SHL 3'd6 // Shift by arg[3:0], C is last bit out
`define ALU_SHR 3'd7 // Logical shift right

`endif

/* list.f */
+incdir+include
src/cpu16_pkg.sv
src/fetch_unit.sv
src/instruction_decode.sv
src/exec_unit.sv
src/mem_port.sv
src/cpu16_top.sv
test/tb_cpu16.sv

/* src/cpu16_pkg.sv */
// Types shared by the cpu16 blocks: words, register numbers, flags, phases, control and memory request
`include "cpu16_params.svh"

package cpu16_pkg;

	typedef logic [`CPU16_WORD_W-1:0]        word_t;    // Data or address word
	typedef logic [$clog2(`CPU16_NREG)-1:0]  reg_idx_t; // Register number
	typedef logic [3:0]                      flags_t;   // {C, Z, P, N}

	// Instruction phases, one instruction in flight
	typedef enum logic [1:0] {
		PH_FETCH   = 2'd0, // Waiting for the instruction word
		PH_DECODE  = 2'd1, // Register and decode
		PH_EXECUTE = 2'd2, // Register file and ALU work
		PH_COMMIT  = 2'd3  // Write back, waits on memory for load/store
	} phase_t;

	// Decoded control word handed to the execute unit
	typedef struct packed {
		logic [1:0] group;     // GPF
		logic [2:0] alu_op;    // ALU_* code
		logic       const_arg; // Use imm instead of Rb
		reg_idx_t   ra;        // Destination or store source
		reg_idx_t   rb;        // Second operand or address register
		logic [3:0] imm;       // 4-bit constant field
		logic       ld;        // Load from memory into Ra
		logic       st;        // Store Ra to memory
		logic       ldi;       // Load immediate into Ra
		logic [1:0] incdec;    // 01 post-inc, 10 post-dec of Rb
		logic       jump;      // Jump taken
		logic       rel;       // PC relative target
		logic       halt;      // Stop after commit
	} ctrl_t;

	// Data memory command
	typedef struct packed {
		logic  write; // 1 store, 0 load
		word_t addr;
		word_t wdata;
	} mem_req_t;

endpackage

/* src/cpu16_top.sv */
// Top level of the cpu16 core joining fetch, decode, execute and data memory port
`timescale 1ns/100ps

module cpu16_top import cpu16_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     imem_ack,
	input  word_t    imem_data,
	input  logic     dmem_ack,
	input  word_t    dmem_rdata,
	output logic     imem_req,
	output word_t    imem_addr,
	output logic     dmem_req,
	output mem_req_t dmem_cmd,
	output logic     halted
);

	logic     fetch_go;
	logic     fetch_done;
	word_t    instr;
	word_t    pc;
	logic     pc_load;
	word_t    pc_target;
	flags_t   flags;
	logic     exec_go;
	ctrl_t    ctrl;
	logic     mem_go;
	mem_req_t mem_cmd;
	logic     mem_done;
	word_t    mem_rdata;

	fetch_unit fetch0 (
		.CLK(CLK), .rst_n(rst_n), .fetch_go(fetch_go), .pc_load(pc_load),
		.pc_target(pc_target), .imem_ack(imem_ack), .imem_data(imem_data),
		.imem_req(imem_req), .imem_addr(imem_addr), .fetch_done(fetch_done),
		.instr(instr), .pc(pc)
	);

	instruction_decode decode0 (
		.CLK(CLK), .rst_n(rst_n), .instr(instr), .fetch_done(fetch_done),
		.flags(flags), .mem_done(mem_done), .fetch_go(fetch_go),
		.exec_go(exec_go), .ctrl(ctrl), .halted(halted)
	);

	exec_unit exec0 (
		.CLK(CLK), .rst_n(rst_n), .exec_go(exec_go), .ctrl(ctrl), .pc(pc),
		.mem_done(mem_done), .mem_rdata(mem_rdata), .flags(flags),
		.pc_load(pc_load), .pc_target(pc_target), .mem_go(mem_go), .mem_cmd(mem_cmd)
	);

	mem_port mem0 (
		.CLK(CLK), .rst_n(rst_n), .mem_go(mem_go), .mem_cmd(mem_cmd),
		.dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata), .mem_done(mem_done),
		.mem_rdata(mem_rdata), .dmem_req(dmem_req), .dmem_cmd(dmem_cmd)
	);

endmodule

/* src/exec_unit.sv */
// Execute unit with register file, ALU, condition flags, memory addressing and jump targets
`timescale 1ns/100ps
`include "cpu16_params.svh"

module exec_unit import cpu16_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     exec_go,
	input  ctrl_t    ctrl,
	input  word_t    pc,        // Already incremented
	input  logic     mem_done,
	input  word_t    mem_rdata,
	output flags_t   flags,     // {C, Z, P, N}
	output logic     pc_load,
	output word_t    pc_target,
	output logic     mem_go,
	output mem_req_t mem_cmd
);

	word_t                 regs [`CPU16_NREG];
	word_t                 a_val;     // Ra
	word_t                 b_val;     // Rb or constant
	word_t                 imm_ext;   // Zero extended constant
	word_t                 alu_res;
	logic [`CPU16_WORD_W:0] alu_wide;  // Carry in the top bit
	logic [`CPU16_WORD_W:0] shr_wide;  // Right shift with a guard bit
	flags_t                alu_flags;

	assign imm_ext  = {{(`CPU16_WORD_W-4){1'b0}}, ctrl.imm};
	assign a_val    = regs[ctrl.ra];
	assign b_val    = ctrl.const_arg ? imm_ext : regs[ctrl.rb];
	assign shr_wide = {a_val, 1'b0} >> b_val[3:0]; // Bit 0 is last bit out

	always_comb begin
		alu_wide = {1'b0, b_val};
		case (ctrl.alu_op)
			`ALU_MOV: alu_wide = {1'b0, b_val};
			`ALU_ADD: alu_wide = {1'b0, a_val} + {1'b0, b_val};
			`ALU_SUB: alu_wide = {1'b0, a_val} - {1'b0, b_val}; // Top bit is borrow
			`ALU_AND: alu_wide = {1'b0, a_val & b_val};
			`ALU_OR:  alu_wide = {1'b0, a_val | b_val};
			`ALU_XOR: alu_wide = {1'b0, a_val ^ b_val};
			`ALU_SHL: alu_wide = {1'b0, a_val} << b_val[3:0];
			`ALU_SHR: alu_wide = {shr_wide[0], shr_wide[`CPU16_WORD_W:1]};
		endcase
	end

	assign alu_res = alu_wide[`CPU16_WORD_W-1:0];
	// P set on an even number of ones
	assign alu_flags = {alu_wide[`CPU16_WORD_W], alu_res == '0, ~^alu_res,
		alu_res[`CPU16_WORD_W-1]};

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU16_NREG; i++)
				regs[i] <= '0;
			flags   <= '0;
			pc_load <= 1'b0;
			mem_go  <= 1'b0;
		end else begin
			pc_load <= 1'b0;
			mem_go  <= 1'b0;
			if (exec_go) begin
				if (ctrl.group == 2'b11) begin
					regs[ctrl.ra] <= alu_res;
					flags         <= alu_flags; // Only group 3 touches flags
				end
				if (ctrl.ldi)
					regs[ctrl.ra] <= imm_ext;
				if (ctrl.ld || ctrl.st)
					mem_go <= 1'b1; // Transfer runs in commit
				pc_load <= ctrl.jump;
			end
			if (mem_done) begin
				if (ctrl.ld)
					regs[ctrl.ra] <= mem_rdata;
				if (ctrl.incdec == 2'b01)
					regs[ctrl.rb] <= regs[ctrl.rb] + word_t'(1); // Wins over load when Ra is Rb
				else if (ctrl.incdec == 2'b10)
					regs[ctrl.rb] <= regs[ctrl.rb] - word_t'(1);
			end
		end
	end

	// Jump target and memory command, sampled with exec_go
	always_ff @(posedge CLK) begin
		if (exec_go) begin
			pc_target <= ctrl.rel ? pc + regs[ctrl.rb] : regs[ctrl.rb];
			mem_cmd   <= '{write: ctrl.st, addr: regs[ctrl.rb], wdata: a_val};
		end
	end

endmodule

/* src/fetch_unit.sv */
// Instruction fetch unit holding the program counter and reading words over a four-phase port
`timescale 1ns/100ps
`include "cpu16_params.svh"

module fetch_unit import cpu16_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  fetch_go,   // Fetch strobe from decoder
	input  logic  pc_load,    // Taken jump
	input  word_t pc_target,  // Jump destination
	input  logic  imem_ack,
	input  word_t imem_data,
	output logic  imem_req,
	output word_t imem_addr,
	output logic  fetch_done, // One cycle, instr valid with it
	output word_t instr,
	output word_t pc          // Next fetch address
);

	typedef enum logic [1:0] {
		F_IDLE, // No transfer
		F_REQ,  // req high, waiting for ack
		F_REL   // req dropped, waiting for ack low
	} fstate_t;

	fstate_t state;
	logic    go_pend; // Strobe held until the port is free
	logic    start;   // Raise req this cycle
	logic    got_ack; // Data accepted this cycle

	assign start     = (state == F_IDLE) && (fetch_go || go_pend) && !imem_ack;
	assign got_ack   = (state == F_REQ) && imem_ack;
	assign imem_addr = pc; // PC only moves after req has dropped

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state      <= F_IDLE;
			go_pend    <= 1'b0;
			imem_req   <= 1'b0;
			fetch_done <= 1'b0;
			pc         <= `CPU16_RESET_PC;
		end else begin
			fetch_done <= got_ack;
			if (start)
				go_pend <= 1'b0;
			else if (fetch_go)
				go_pend <= 1'b1; // Ack still high or transfer busy
			if (pc_load)
				pc <= pc_target;
			else if (got_ack)
				pc <= pc + word_t'(1); // Word addressed
			case (state)
				F_IDLE: if (start) begin
					imem_req <= 1'b1;
					state    <= F_REQ;
				end
				F_REQ: if (imem_ack) begin
					imem_req <= 1'b0; // Data captured, release
					state    <= F_REL;
				end
				F_REL: if (!imem_ack)
					state <= F_IDLE;
				default: state <= F_IDLE;
			endcase
		end
	end

	// Instruction word, valid from fetch_done on
	always_ff @(posedge CLK) begin
		if (got_ack)
			instr <= imem_data;
	end

endmodule

/* src/instruction_decode.sv */
// Instruction decoder sequencing fetch, decode, execute and commit and building the control word
`timescale 1ns/100ps
`include "cpu16_params.svh"

module instruction_decode import cpu16_pkg::*; (
	input  logic   CLK,
	input  logic   rst_n,
	input  word_t  instr,      // Held by the fetch unit
	input  logic   fetch_done,
	input  flags_t flags,      // {C, Z, P, N}
	input  logic   mem_done,
	output logic   fetch_go,   // One cycle in PH_FETCH
	output logic   exec_go,    // Whole PH_EXECUTE cycle
	output ctrl_t  ctrl,
	output logic   halted
);

	phase_t     phase;
	logic       fetch_sent; // Strobe already given this fetch
	logic       is_mem;     // Commit waits for memory
	logic       flag_sel;   // Flag chosen by CCF
	ctrl_t      dec;        // Decode of the current word
	logic [1:0] gpf;
	logic [2:0] sysf;
	logic [1:0] incf;
	logic [1:0] ldsf;
	logic [1:0] modef;
	logic [1:0] skipf;
	logic [1:0] jpf;
	logic [1:0] ccf;
	logic [3:0] aluf;
	logic [1:0] argf;

	// Group fields, positions per format
	assign gpf   = instr[15:14];
	assign sysf  = instr[13:11];
	assign incf  = instr[13:12];
	assign ldsf  = instr[11:10];
	assign modef = instr[9:8];
	assign skipf = instr[13:12];
	assign jpf   = instr[11:10];
	assign ccf   = instr[9:8];
	assign aluf  = instr[13:10];
	assign argf  = instr[9:8];

	always_comb begin
		case (ccf)
			2'b00:   flag_sel = flags[3]; // Carry
			2'b01:   flag_sel = flags[2]; // Zero
			2'b10:   flag_sel = flags[1]; // Parity
			default: flag_sel = flags[0]; // Negative
		endcase
	end

	always_comb begin
		dec       = '0;
		dec.group = gpf;
		dec.ra    = instr[7:4];
		dec.rb    = instr[3:0];
		dec.imm   = instr[3:0];
		case (gpf)
			2'b00: dec.halt = (sysf == 3'b001); // Other SYSF codes are NOP
			2'b01: begin
				dec.incdec = incf;
				dec.ldi    = (modef == 2'b01); // No memory access
				dec.st     = !dec.ldi && ldsf[0];
				dec.ld     = !dec.ldi && !ldsf[0];
			end
			2'b10: begin
				// SKIPF[1] conditional, SKIPF[0] jump on flag set
				dec.jump = skipf[1] ? (skipf[0] ? flag_sel : !flag_sel) : 1'b1;
				dec.rel  = jpf[0];
			end
			default: begin
				dec.alu_op    = aluf[3] ? `ALU_MOV : aluf[2:0]; // 8..15 fold to MOV
				dec.const_arg = argf[0];
			end
		endcase
	end

	assign fetch_go = (phase == PH_FETCH) && !fetch_sent && !halted;
	assign exec_go  = (phase == PH_EXECUTE);
	assign is_mem   = ctrl.ld || ctrl.st;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			phase      <= PH_FETCH;
			fetch_sent <= 1'b0;
			halted     <= 1'b0;
			ctrl       <= '0; // Decodes as NOP
		end else begin
			case (phase)
				PH_FETCH: begin
					if (fetch_go)
						fetch_sent <= 1'b1;
					if (fetch_done) begin
						fetch_sent <= 1'b0;
						phase      <= PH_DECODE;
					end
				end
				PH_DECODE: begin
					ctrl  <= dec; // Flags are settled by now
					phase <= PH_EXECUTE;
				end
				PH_EXECUTE: phase <= PH_COMMIT;
				default: if (!is_mem || mem_done) begin
					halted <= halted || ctrl.halt; // Blocks further fetches
					phase  <= PH_FETCH;
				end
			endcase
		end
	end

endmodule

/* src/mem_port.sv */
// Data memory master running load and store transfers over a four-phase req/ack port
`timescale 1ns/100ps

module mem_port import cpu16_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     mem_go,     // Start strobe from execute unit
	input  mem_req_t mem_cmd,
	input  logic     dmem_ack,
	input  word_t    dmem_rdata,
	output logic     mem_done,   // One cycle after ack falls
	output word_t    mem_rdata,
	output logic     dmem_req,
	output mem_req_t dmem_cmd    // Stable while req is high
);

	typedef enum logic [1:0] {
		M_IDLE, // Ack already low here
		M_REQ,  // req high, waiting for ack
		M_REL   // req dropped, waiting for ack low
	} mstate_t;

	mstate_t state;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state    <= M_IDLE;
			dmem_req <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			case (state)
				M_IDLE: if (mem_go) begin
					dmem_req <= 1'b1;
					state    <= M_REQ;
				end
				M_REQ: if (dmem_ack) begin
					dmem_req <= 1'b0; // Read data taken this edge
					state    <= M_REL;
				end
				M_REL: if (!dmem_ack) begin
					mem_done <= 1'b1; // Port free for the next command
					state    <= M_IDLE;
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == M_IDLE && mem_go)
			dmem_cmd <= mem_cmd;
		if (state == M_REQ && dmem_ack)
			mem_rdata <= dmem_rdata; // Ignored on stores
	end

endmodule

/* test/tb_cpu16.sv */
// Directed testbench for the cpu16 core with instruction and data memory models
`timescale 1ns/100ps
`include "cpu16_params.svh"

module tb_cpu16 import cpu16_pkg::*; ();

	logic     CLK;
	logic     rst_n;
	logic     imem_ack, dmem_ack, imem_req, dmem_req, halted;
	word_t    imem_data, dmem_rdata, imem_addr;
	mem_req_t dmem_cmd;
	word_t    imem [256];
	word_t    dmem [256];
	word_t    st_addr[$], st_data[$];   // Stores seen by the data memory
	word_t    exp_addr[$], exp_data[$]; // Stores the program should make
	int       icnt, dcnt, wp, sa;       // Ack delays, write pointer, store slot
	int       err_cnt, tmo_cnt;
	logic     rand_mode;                // Random ack delays

	cpu16_top dut0 (
		.CLK(CLK), .rst_n(rst_n), .imem_ack(imem_ack), .imem_data(imem_data),
		.dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata), .imem_req(imem_req),
		.imem_addr(imem_addr), .dmem_req(dmem_req), .dmem_cmd(dmem_cmd), .halted(halted)
	);

	always #50 CLK = ~CLK;

	function int next_delay();
		return rand_mode ? int'($urandom % 4) : 0;
	endfunction

	always @(posedge CLK) begin // Instruction memory responder
		if (!rst_n) begin
			imem_ack <= 1'b0;
			icnt     <= 0;
		end else if (imem_req && !imem_ack) begin
			if (icnt == 0) begin
				imem_ack  <= 1'b1;
				imem_data <= imem[imem_addr[7:0]];
				icnt      <= next_delay();
			end else
				icnt <= icnt - 1;
		end else if (!imem_req && imem_ack)
			imem_ack <= 1'b0;
	end

	always @(posedge CLK) begin // Data memory responder logging stores
		if (!rst_n) begin
			dmem_ack <= 1'b0;
			dcnt     <= 0;
		end else if (dmem_req && !dmem_ack) begin
			if (dcnt == 0) begin
				dmem_ack <= 1'b1;
				dcnt     <= next_delay();
				if (dmem_cmd.write) begin
					dmem[dmem_cmd.addr[7:0]] = dmem_cmd.wdata;
					st_addr.push_back(dmem_cmd.addr);
					st_data.push_back(dmem_cmd.wdata);
				end else
					dmem_rdata <= dmem[dmem_cmd.addr[7:0]];
			end else
				dcnt <= dcnt - 1;
		end else if (!dmem_req && dmem_ack)
			dmem_ack <= 1'b0;
	end

	function word_t dfill(input int a);
		return word_t'(a) ^ 16'hA5C3; // Initial data memory contents
	endfunction

	// Instruction encoders per group format
	function word_t op_alu(input logic [2:0] op, input reg_idx_t ra, input reg_idx_t rb,
		input logic k);
		return {2'b11, 1'b0, op, 1'b0, k, ra, rb};
	endfunction

	function word_t op_mem(input logic [1:0] incf, input logic st, input logic ldi,
		input reg_idx_t ra, input reg_idx_t rb);
		return {2'b01, incf, 1'b0, st, 1'b0, ldi, ra, rb};
	endfunction

	function word_t op_jump(input logic cond, input logic pol, input logic rel,
		input logic [1:0] ccf, input reg_idx_t rb);
		return {2'b10, cond, pol, 1'b0, rel, ccf, 4'd0, rb};
	endfunction

	// {carry, result} by the opcode table
	function logic [16:0] ref_alu(input logic [2:0] op, input word_t a, input word_t b);
		int n;
		n = int'(b[3:0]);
		case (op)
			`ALU_MOV: return {1'b0, b};
			`ALU_ADD: return {1'b0, a} + {1'b0, b};
			`ALU_SUB: return {a < b, a - b}; // Borrow
			`ALU_AND: return {1'b0, a & b};
			`ALU_OR:  return {1'b0, a | b};
			`ALU_XOR: return {1'b0, a ^ b};
			`ALU_SHL: return {(n == 0) ? 1'b0 : a[16-n], a << n};
			default:  return {(n == 0) ? 1'b0 : a[n-1], a >> n};
		endcase
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_addr(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic emit(input word_t w);
		imem[wp] = w;
		wp++;
	endtask

	task automatic expect_store(input word_t d);
		exp_addr.push_back(word_t'(sa));
		exp_data.push_back(d);
		sa++;
	endtask

	task automatic new_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 16'h0800 | word_t'(i); // Decodes as HALT
			dmem[i] = dfill(i);
		end
		exp_addr.delete();
		exp_data.delete();
		wp = 0;
		sa = 0;
	endtask

	// Reset, run to HALT and compare the store log
	task automatic run_program(input string name);
		int n;
		@(posedge CLK);
		rst_n <= 1'b0;
		repeat (2) @(posedge CLK);
		st_addr.delete();
		st_data.delete();
		rst_n <= 1'b1;
		@(negedge CLK);
		check_word("imem_req", word_t'(imem_req), 16'h0);
		check_word("dmem_req", word_t'(dmem_req), 16'h0);
		for (n = 0; n < 100 && !imem_req; n++)
			@(negedge CLK);
		if (!imem_req) begin
			$display("%s: first instruction fetch never started", name);
			tmo_cnt++;
		end else
			check_addr("imem_addr", imem_addr, `CPU16_RESET_PC);
		for (n = 0; n < 20000 && !halted; n++)
			@(negedge CLK);
		if (!halted) begin
			$display("%s: core did not halt in time", name);
			tmo_cnt++;
		end
		for (n = 0; n < 40; n++) begin // Quiet window after HALT
			@(negedge CLK);
			if (imem_req && halted) begin
				$display("%s: instruction fetch issued after halt", name);
				err_cnt++;
				break;
			end
		end
		if (st_addr.size() != exp_addr.size()) begin
			$display("%s: %0d stores seen, %0d expected", name, st_addr.size(),
				exp_addr.size());
			err_cnt++;
		end
		for (int i = 0; i < st_addr.size() && i < exp_addr.size(); i++) begin
			check_addr("dmem_cmd.addr", st_addr[i], exp_addr[i]);
			check_word("dmem_cmd.wdata", st_data[i], exp_data[i]);
		end
	endtask

	task automatic test_alu();
		logic [16:0] r;
		new_program();
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd1, 4'd9));
		emit(op_alu(`ALU_SHL, 4'd1, 4'd12, 1'b1)); // R1 = 0x9000
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd4, 4'd9));
		emit(op_alu(`ALU_OR, 4'd1, 4'd4, 1'b0));   // R1 = 0x9009
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd2, 4'd5));
		for (int op = 0; op < 8; op++) begin
			for (int k = 0; k < 2; k++) begin
				emit(op_alu(`ALU_MOV, 4'd3, 4'd1, 1'b0));
				emit(op_alu(3'(op), 4'd3, k ? 4'd6 : 4'd2, k[0]));
				emit(op_mem(2'b01, 1'b1, 1'b0, 4'd3, 4'd15)); // Store via R15 post-inc
				r = ref_alu(3'(op), 16'h9009, k ? 16'd6 : 16'd5);
				expect_store(r[15:0]);
			end
		end
		run_program("alu");
	endtask

	task automatic test_ldst();
		new_program();
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd5, 4'd4));  // R5 = 4
		emit(op_mem(2'b01, 1'b0, 1'b0, 4'd6, 4'd5));  // R6 = M[4], R5 = 5
		emit(op_mem(2'b10, 1'b0, 1'b0, 4'd7, 4'd5));  // R7 = M[5], R5 = 4
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd8, 4'd7));
		emit(op_mem(2'b01, 1'b1, 1'b0, 4'd8, 4'd5));
		emit(op_mem(2'b10, 1'b1, 1'b0, 4'd6, 4'd5));
		emit(op_mem(2'b00, 1'b1, 1'b0, 4'd7, 4'd5));
		emit(op_mem(2'b00, 1'b1, 1'b0, 4'd5, 4'd5));
		emit(op_mem(2'b00, 1'b0, 1'b0, 4'd9, 4'd5));  // Reads back the last store
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd10, 4'd10));
		emit(op_mem(2'b00, 1'b1, 1'b0, 4'd9, 4'd10));
		exp_addr = {16'd4, 16'd5, 16'd4, 16'd4, 16'd10};
		exp_data = {16'd7, dfill(4), dfill(5), 16'd4, 16'd4};
		run_program("ldst");
	endtask

	task automatic test_jump();
		logic [16:0] r;
		flags_t      fl;
		logic        taken;
		int          idx;
		new_program();
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd12, 4'd1));
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd14, 4'd15));
		emit(op_mem(2'b00, 1'b0, 1'b1, 4'd11, 4'd5));
		emit(op_jump(1'b0, 1'b0, 1'b0, 2'd0, 4'd11)); // Absolute to 5
		emit(op_mem(2'b01, 1'b1, 1'b0, 4'd14, 4'd15));
		emit(op_jump(1'b0, 1'b0, 1'b1, 2'd0, 4'd12)); // Relative skip of one
		emit(op_mem(2'b01, 1'b1, 1'b0, 4'd14, 4'd15));
		idx = 0;
		for (int s = 0; s < 3; s++) begin
			for (int c = 0; c < 4; c++) begin
				for (int p = 0; p < 2; p++) begin
					emit(op_mem(2'b00, 1'b0, 1'b1, 4'd13, 4'(idx)));
					if (s == 0) begin
						emit(op_mem(2'b00, 1'b0, 1'b1, 4'd3, 4'd0));
						emit(op_alu(`ALU_SUB, 4'd3, 4'd1, 1'b1));
						r = ref_alu(`ALU_SUB, 16'd0, 16'd1);
					end else begin
						emit(op_alu(`ALU_MOV, 4'd3, 4'(s - 1), 1'b1));
						r = ref_alu(`ALU_MOV, 16'd0, word_t'(s - 1));
					end
					fl    = {r[16], r[15:0] == 16'd0, ~^r[15:0], r[15]};
					taken = p ? fl[3-c] : !fl[3-c];
					emit(op_jump(1'b1, p[0], 1'b1, 2'(c), 4'd12));
					emit(op_mem(2'b01, 1'b1, 1'b0, 4'd13, 4'd15)); // Not-taken path
					emit(op_mem(2'b01, 1'b1, 1'b0, 4'd14, 4'd15)); // Join
					if (!taken)
						expect_store(word_t'(idx[3:0]));
					expect_store(16'd15);
					idx++;
				end
			end
		end
		run_program("jump");
	endtask

	initial begin
		void'($urandom(73803));
		CLK        = 1'b0;
		rst_n      <= 1'b0;
		imem_ack   <= 1'b0;
		imem_data  <= '0;
		dmem_ack   <= 1'b0;
		dmem_rdata <= '0;
		err_cnt    = 0;
		tmo_cnt    = 0;
		for (int m = 0; m < 2; m++) begin // Zero delay first then random ack delays
			rand_mode = m[0];
			test_alu();
			test_ldst();
			test_jump();
		end
		$display("Errors: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
